// File: dptx_msa_params.svh
// ----------------------------------------
// DP TX MSA inserter constants
// Link geometry, RAM sizing, read counts
// and the control symbol codes
// ----------------------------------------
`ifndef DPTX_MSA_PARAMS_SVH
`define DPTX_MSA_PARAMS_SVH

// Link geometry
`define MSA_LANES       4
`define MSA_SPL         2
`define MSA_NUM_RAM     8               // Lanes times symbols per lane
`define MSA_RAM_ADR     5
`define MSA_SYM_W       9               // K flag plus byte

// Message
`define MSA_MSG_IDX     5
`define MSA_MSG_DAT     16

`define MSA_IDLE_MAX    8190            // Idle symbols between sequences

// RAM addresses read per vsync
`define MSA_RD_CNT_4L   6
`define MSA_RD_CNT_2L   11
`define MSA_RD_CNT_1L   20

`define MSA_BS_CNT_EFM  3               // Beats per enhanced sequence
`define MSA_BS_CNT_NRM  2
`define MSA_SYM_BS      9'h1bc          // K28.5
`define MSA_SYM_BF      9'h1f7          // K23.7
`define MSA_VBID_NOVID  8'h09

`endif

// File: dptx_msa_pkg.sv
// ----------------------------------------
// DP TX MSA types
// Message word, link symbol, link beat
// and RAM readout bundle
// ----------------------------------------
`default_nettype none

`include "dptx_msa_params.svh"

package dptx_msa_pkg;

    // 1 is one lane, 2 two lanes, 3 four lanes
    typedef logic [1:0] lane_mode_t;

    typedef struct packed {
        logic [`MSA_MSG_IDX-1:0]    idx;    // Word index within the block
        logic                       first;
        logic                       last;
        logic [`MSA_MSG_DAT-1:0]    dat;
        logic                       vld;
    } msa_msg_t;

    // Symbol as sent on a lane
    typedef struct packed {
        logic                       k;
        logic [7:0]                 dat;
    } sym_ks_t;

    // Same RAM word, seen raw or as k flag and byte
    typedef union packed {
        logic [`MSA_SYM_W-1:0]      raw;
        sym_ks_t                    ks;
    } sym_t;

    typedef sym_t [`MSA_LANES-1:0][`MSA_SPL-1:0] lnk_beat_t;

    typedef struct packed {
        sym_t [`MSA_NUM_RAM-1:0]    dat;    // Index is lane * spl + sublane
        logic                       de;
    } msa_rd_t;

endpackage

`default_nettype wire

// File: dptx_msa_top.sv
// ----------------------------------------
// DP TX MSA inserter
// Stores the MSA block from messages and
// inserts it and the blanking start
// sequences into the four lane link
// ----------------------------------------
`default_nettype none

`include "dptx_msa_params.svh"

module dptx_msa_top
(
    input wire                              LNK_CLK_IN,
    input wire                              LNK_RST_IN,
    input wire dptx_msa_pkg::lane_mode_t    lanes,
    input wire                              efm,
    input wire                              vid_en,
    input wire                              vs,
    input wire                              vbf,
    input wire                              bs,
    input wire [7:0]                        mvid_lsb,
    input wire dptx_msa_pkg::msa_msg_t      msg,
    input wire dptx_msa_pkg::lnk_beat_t     lnk_in,
    output dptx_msa_pkg::lnk_beat_t         lnk_out
);

    import dptx_msa_pkg::*;

    logic [`MSA_NUM_RAM-1:0]    wr;
    logic [`MSA_RAM_ADR-1:0]    wp;
    sym_t                       din;
    lane_mode_t                 lanes_q;    // Registered lane mode
    logic                       efm_q;
    logic                       run;
    logic                       vs_re;
    logic                       vbf_q;
    logic [1:0]                 bs_cnt;
    logic                       bs_end;
    msa_rd_t                    rd;

    msa_frame_ctl u_frame_ctl
    (
        .LNK_CLK_IN (LNK_CLK_IN),
        .LNK_RST_IN (LNK_RST_IN),
        .lanes_in   (lanes),
        .efm_in     (efm),
        .vid_en     (vid_en),
        .vs         (vs),
        .vbf        (vbf),
        .bs         (bs),
        .lanes      (lanes_q),
        .efm        (efm_q),
        .run        (run),
        .vs_re      (vs_re),
        .vbf_q      (vbf_q),
        .bs_cnt     (bs_cnt),
        .bs_end     (bs_end)
    );

    msa_msg_writer u_msg_writer
    (
        .LNK_CLK_IN (LNK_CLK_IN),
        .LNK_RST_IN (LNK_RST_IN),
        .lanes      (lanes_q),
        .msg        (msg),
        .wr         (wr),
        .wp         (wp),
        .din        (din)
    );

    msa_store u_store
    (
        .LNK_CLK_IN (LNK_CLK_IN),
        .LNK_RST_IN (LNK_RST_IN),
        .wr         (wr),
        .wp         (wp),
        .din        (din),
        .lanes      (lanes_q),
        .vs_re      (vs_re),
        .rd         (rd)
    );

    msa_link_mux u_link_mux
    (
        .LNK_CLK_IN (LNK_CLK_IN),
        .rd         (rd),
        .run        (run),
        .efm        (efm_q),
        .vbf_q      (vbf_q),
        .bs_cnt     (bs_cnt),
        .bs_end     (bs_end),
        .mvid_lsb   (mvid_lsb),
        .lnk_in     (lnk_in),
        .lnk_out    (lnk_out)
    );

endmodule

`default_nettype wire

// File: msa_frame_ctl.sv
// ----------------------------------------
// MSA frame control
// Input registers, run flag, vsync edge,
// idle timer and blanking start countdown
// ----------------------------------------
`default_nettype none

`include "dptx_msa_params.svh"

module msa_frame_ctl
(
    input wire                              LNK_CLK_IN,
    input wire                              LNK_RST_IN,
    input wire dptx_msa_pkg::lane_mode_t    lanes_in,
    input wire                              efm_in,
    input wire                              vid_en,
    input wire                              vs,
    input wire                              vbf,
    input wire                              bs,
    output dptx_msa_pkg::lane_mode_t        lanes,
    output logic                            efm,
    output logic                            run,
    output logic                            vs_re,
    output logic                            vbf_q,
    output logic [1:0]                      bs_cnt,
    output logic                            bs_end
);

    logic           en_q;
    logic           vs_q;
    logic           vs_d;
    logic           bs_q;
    logic [12:0]    idle_cnt;
    logic           idle_ld;    // Idle period elapsed

    always_ff @(posedge LNK_CLK_IN, posedge LNK_RST_IN)
    begin
        if (LNK_RST_IN)
        begin
            lanes    <= '0;
            efm      <= 1'b0;
            en_q     <= 1'b0;
            vs_q     <= 1'b0;
            vs_d     <= 1'b0;
            vs_re    <= 1'b0;
            vbf_q    <= 1'b0;
            bs_q     <= 1'b0;
            run      <= 1'b0;
            idle_cnt <= '0;
            idle_ld  <= 1'b0;
        end
        else
        begin
            lanes <= lanes_in;
            efm   <= efm_in;
            en_q  <= vid_en;
            vs_q  <= vs;
            vbf_q <= vbf;
            bs_q  <= bs;
            vs_d  <= vs_q;
            vs_re <= vs_q & ~vs_d;              // Registered rising edge

            if (!en_q)
                run <= 1'b0;
            else if (vs_re)
                run <= 1'b1;                    // Video starts at a frame boundary

            // Free running while no video
            idle_ld <= 1'b0;
            if (run)
                idle_cnt <= '0;
            else if (idle_cnt >= 13'(`MSA_IDLE_MAX))
            begin
                idle_cnt <= '0;
                idle_ld  <= 1'b1;
            end
            else
                idle_cnt <= idle_cnt + 13'(`MSA_SPL);
        end
    end

    always_ff @(posedge LNK_CLK_IN, posedge LNK_RST_IN)
    begin
        if (LNK_RST_IN)
            bs_cnt <= '0;
        else if (idle_ld || (bs_q && run))
            bs_cnt <= efm ? 2'(`MSA_BS_CNT_EFM) : 2'(`MSA_BS_CNT_NRM);
        else if (!bs_end)
            bs_cnt <= bs_cnt - 1'b1;
    end

    assign bs_end = (bs_cnt == 2'd0);

endmodule

`default_nettype wire

// File: msa_link_mux.sv
// ----------------------------------------
// MSA link mux
// Output beat register choosing MSA data,
// blanking start symbols or link input
// ----------------------------------------
`default_nettype none

`include "dptx_msa_params.svh"

module msa_link_mux
(
    input wire                              LNK_CLK_IN,
    input wire dptx_msa_pkg::msa_rd_t       rd,
    input wire                              run,
    input wire                              efm,
    input wire                              vbf_q,
    input wire [1:0]                        bs_cnt,
    input wire                              bs_end,
    input wire [7:0]                        mvid_lsb,
    input wire dptx_msa_pkg::lnk_beat_t     lnk_in,
    output dptx_msa_pkg::lnk_beat_t         lnk_out
);

    import dptx_msa_pkg::*;

    logic [7:0]             vbid;
    logic [7:0]             mvid;
    sym_t [`MSA_SPL-1:0]    bs_sym;     // Same beat on every lane

    assign vbid = run ? {7'b0, vbf_q} : `MSA_VBID_NOVID;
    assign mvid = run ? mvid_lsb : 8'h00;

    always_comb
    begin
        bs_sym = '0;
        if (efm)
        begin
            case (bs_cnt)
                2'd3 :
                begin
                    bs_sym[0].raw = `MSA_SYM_BS;
                    bs_sym[1].raw = `MSA_SYM_BF;
                end
                2'd2 :
                begin
                    bs_sym[0].raw = `MSA_SYM_BF;
                    bs_sym[1].raw = `MSA_SYM_BS;
                end
                default :
                begin
                    bs_sym[0].ks.dat = vbid;
                    bs_sym[1].ks.dat = mvid;
                end
            endcase
        end
        else if (bs_cnt == 2'd2)
        begin
            bs_sym[0].raw    = `MSA_SYM_BS;
            bs_sym[1].ks.k   = 1'b0;
            bs_sym[1].ks.dat = vbid;
        end
        else
            bs_sym[0].ks.dat = mvid;            // Second symbol stays zero
    end

    // MSA readout wins over a pending sequence
    always_ff @(posedge LNK_CLK_IN)
    begin
        if (rd.de)
        begin
            for (int l = 0; l < `MSA_LANES; l++)
                for (int s = 0; s < `MSA_SPL; s++)
                    lnk_out[l][s] <= rd.dat[l*`MSA_SPL + s];
        end
        else if (!bs_end)
        begin
            for (int l = 0; l < `MSA_LANES; l++)
                lnk_out[l] <= bs_sym;
        end
        else
            lnk_out <= lnk_in;
    end

endmodule

`default_nettype wire

// File: msa_msg_writer.sv
// ----------------------------------------
// MSA message writer
// Spreads message words over the lane and
// sublane RAMs and steps the write pointer
// ----------------------------------------
`default_nettype none

`include "dptx_msa_params.svh"

module msa_msg_writer
(
    input wire                              LNK_CLK_IN,
    input wire                              LNK_RST_IN,
    input wire dptx_msa_pkg::lane_mode_t    lanes,
    input wire dptx_msa_pkg::msa_msg_t      msg,
    output logic [`MSA_NUM_RAM-1:0]         wr,
    output logic [`MSA_RAM_ADR-1:0]         wp,
    output dptx_msa_pkg::sym_t              din
);

    logic [2:0] sel;        // RAM number, lane * 2 + sublane
    logic [2:0] top_sel;    // Highest active RAM

    // Lane is idx mod L, sublane the next index bit
    always_comb
    begin
        case (lanes)
            2'd3    : sel = {msg.idx[1:0], msg.idx[2]};
            2'd2    : sel = {1'b0, msg.idx[0], msg.idx[1]};
            default : sel = {2'b00, msg.idx[0]};
        endcase
    end

    assign top_sel = {(lanes == 2'd3), lanes[1], 1'b1};   // 7, 3 or 1

    always_comb
    begin
        wr = '0;
        if (msg.vld)
            wr[sel] = 1'b1;
    end

    always_comb
        din.raw = msg.dat[`MSA_SYM_W-1:0];

    always_ff @(posedge LNK_CLK_IN, posedge LNK_RST_IN)
    begin
        if (LNK_RST_IN)
            wp <= '0;
        else if (msg.vld && msg.last)
            wp <= '0;                       // Ready for the next block
        else if (wr[top_sel])
            wp <= wp + 1'b1;
    end

endmodule

`default_nettype wire

// File: msa_store.sv
// ----------------------------------------
// MSA store
// Eight sublane memories with a shared
// read port, read out after each vsync
// ----------------------------------------
`default_nettype none

`include "dptx_msa_params.svh"

module msa_store
(
    input wire                              LNK_CLK_IN,
    input wire                              LNK_RST_IN,
    input wire [`MSA_NUM_RAM-1:0]           wr,
    input wire [`MSA_RAM_ADR-1:0]           wp,
    input wire dptx_msa_pkg::sym_t          din,
    input wire dptx_msa_pkg::lane_mode_t    lanes,
    input wire                              vs_re,
    output dptx_msa_pkg::msa_rd_t           rd
);

    import dptx_msa_pkg::*;

    logic [`MSA_RAM_ADR-1:0]    rd_cnt;
    logic [`MSA_RAM_ADR-1:0]    rp;
    logic                       rd_en;
    logic                       de;
    sym_t                       dout [0:`MSA_NUM_RAM-1];

    generate
        for (genvar i = 0; i < `MSA_NUM_RAM; i++)
        begin : gen_ram
            sym_t mem [0:(1 << `MSA_RAM_ADR)-1];

            always_ff @(posedge LNK_CLK_IN)
            begin
                if (wr[i])
                    mem[wp] <= din;
                if (rd_en)
                    dout[i] <= mem[rp];     // One cycle read latency
            end
        end
    endgenerate

    assign rd_en = (rd_cnt != '0);

    always_ff @(posedge LNK_CLK_IN, posedge LNK_RST_IN)
    begin
        if (LNK_RST_IN)
        begin
            rd_cnt <= '0;
            rp     <= '0;
            de     <= 1'b0;
        end
        else
        begin
            de <= rd_en;
            if (vs_re)
            begin
                rp <= '0;
                case (lanes)
                    2'd3    : rd_cnt <= `MSA_RAM_ADR'(`MSA_RD_CNT_4L);
                    2'd2    : rd_cnt <= `MSA_RAM_ADR'(`MSA_RD_CNT_2L);
                    default : rd_cnt <= `MSA_RAM_ADR'(`MSA_RD_CNT_1L);
                endcase
            end
            else if (rd_en)
            begin
                rp     <= rp + 1'b1;
                rd_cnt <= rd_cnt - 1'b1;
            end
        end
    end

    always_comb
    begin
        for (int i = 0; i < `MSA_NUM_RAM; i++)
            rd.dat[i] = dout[i];
        rd.de = de;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
dptx_msa_pkg.sv
msa_msg_writer.sv
msa_store.sv
msa_frame_ctl.sv
msa_link_mux.sv
dptx_msa_top.sv
tb_msa_checker.sv
tb_dptx_msa.sv

// File: tb_dptx_msa.sv
// ----------------------------------------
// DP TX MSA inserter testbench
// Clock, reset, message and link stimulus
// for all lane modes and framing modes,
// with a watchdog on the whole run
// ----------------------------------------
`default_nettype none

`include "dptx_msa_params.svh"

module tb_dptx_msa;

    timeunit 1ns;
    timeprecision 100ps;

    import dptx_msa_pkg::*;

    localparam int CLK_PER    = 4;
    localparam int RST_CYC    = 8;
    localparam int IDLE_CYC   = 8400;     // Two idle periods and some slack
    localparam int MSA_CYC    = 120;      // One lane mode, write plus readout
    localparam int BS_CYC     = 160;
    localparam int MARGIN_CYC = 500;
    localparam int TOTAL_CYC  = RST_CYC + IDLE_CYC + 3 * MSA_CYC + BS_CYC;

    logic           LNK_CLK_IN;
    logic           LNK_RST_IN;
    lane_mode_t     lanes;
    logic           efm;
    logic           vid_en;
    logic           vs;
    logic           vbf;
    logic           bs;
    logic [7:0]     mvid_lsb;
    msa_msg_t       msg;
    lnk_beat_t      lnk_in;
    lnk_beat_t      lnk_out;
    logic [95:0]    test_name;
    logic [31:0]    chk_errs;
    logic [31:0]    chk_cnt;
    logic [31:0]    msa_cnt;
    logic [31:0]    seq_cnt;
    int             tb_errs;
    integer         seed = 32'h28dc43f0;
    logic [95:0]    rnd;

    dptx_msa_top u_dptx_msa_top
    (
        .LNK_CLK_IN (LNK_CLK_IN),
        .LNK_RST_IN (LNK_RST_IN),
        .lanes      (lanes),
        .efm        (efm),
        .vid_en     (vid_en),
        .vs         (vs),
        .vbf        (vbf),
        .bs         (bs),
        .mvid_lsb   (mvid_lsb),
        .msg        (msg),
        .lnk_in     (lnk_in),
        .lnk_out    (lnk_out)
    );

    tb_msa_checker u_checker
    (
        .LNK_CLK_IN (LNK_CLK_IN),
        .LNK_RST_IN (LNK_RST_IN),
        .lanes      (lanes),
        .efm        (efm),
        .vid_en     (vid_en),
        .vs         (vs),
        .vbf        (vbf),
        .bs         (bs),
        .mvid_lsb   (mvid_lsb),
        .msg        (msg),
        .lnk_in     (lnk_in),
        .lnk_out    (lnk_out),
        .test_name  (test_name),
        .err_cnt    (chk_errs),
        .chk_cnt    (chk_cnt),
        .msa_cnt    (msa_cnt),
        .seq_cnt    (seq_cnt)
    );

    initial
        LNK_CLK_IN = 1'b0;

    always #(CLK_PER / 2) LNK_CLK_IN = ~LNK_CLK_IN;

    // Upstream link never stops
    always @(negedge LNK_CLK_IN)
    begin
        rnd = {$random(seed), $random(seed), $random(seed)};
        lnk_in <= rnd[71:0];
    end

    function automatic int reads_for(input lane_mode_t m);
        case (m)
            2'd3    : return `MSA_RD_CNT_4L;
            2'd2    : return `MSA_RD_CNT_2L;
            default : return `MSA_RD_CNT_1L;
        endcase
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge LNK_CLK_IN);
    endtask

    // Waits for MSA or sequence beats, gives up after limit cycles
    task automatic wait_beats(input bit msa, input int target, input int limit);
        int n;
        n = 0;
        while (((msa ? msa_cnt : seq_cnt) < target) && (n < limit))
        begin
            @(negedge LNK_CLK_IN);
            n++;
        end
        if ((msa ? msa_cnt : seq_cnt) < target)
        begin
            tb_errs++;
            $display("Error %0s: expected beats did not appear within %0d cycles",
                     test_name, limit);
        end
    endtask

    task automatic write_block(input lane_mode_t mode);
        int words;
        words = reads_for(mode) * `MSA_SPL * ((mode == 2'd3) ? 4 : int'(mode));
        for (int j = 0; j < words; j++)
        begin
            @(negedge LNK_CLK_IN);
            msg.idx   = 5'(j);
            msg.first = (j == 0);
            msg.last  = (j == words - 1);
            msg.dat   = 16'($random(seed));
            msg.vld   = 1'b1;
        end
        @(negedge LNK_CLK_IN);
        msg = '0;
    endtask

    task automatic pulse_vs();
        int start;
        start = msa_cnt;
        vs = 1'b1;
        wait_cycles(2);
        vs = 1'b0;
        wait_beats(1'b1, start + reads_for(lanes), 40);
    endtask

    task automatic run_msa_test(input lane_mode_t mode, input logic [95:0] name);
        test_name = name;
        lanes = mode;
        wait_cycles(3);                     // Lane mode is registered first
        write_block(mode);
        wait_cycles(2);
        pulse_vs();
    endtask

    // Two pulses, one for each vbf value
    task automatic pulse_bs(input int len);
        int start;
        for (int p = 0; p < 2; p++)
        begin
            vbf = (p == 1);
            mvid_lsb = 8'($random(seed));
            wait_cycles(2);
            start = seq_cnt;
            bs = 1'b1;
            wait_cycles(1);
            bs = 1'b0;
            wait_beats(1'b0, start + len, 20);
        end
    endtask

    initial
    begin
        LNK_RST_IN = 1'b1;
        lanes      = 2'd3;
        efm        = 1'b0;
        vid_en     = 1'b0;
        vs         = 1'b0;
        vbf        = 1'b0;
        bs         = 1'b0;
        mvid_lsb   = 8'h00;
        msg        = '0;
        lnk_in     = '0;
        tb_errs    = 0;
        test_name  = "reset";
        wait_cycles(RST_CYC);
        LNK_RST_IN = 1'b0;

        test_name = "idle";                 // Pass-through plus two idle sequences
        mvid_lsb  = 8'($random(seed)) | 8'h80;  // Nonzero byte that idle beats must hide
        wait_beats(1'b0, 2 * `MSA_BS_CNT_NRM, IDLE_CYC);

        run_msa_test(2'd3, "msa_4l");
        run_msa_test(2'd2, "msa_2l");
        run_msa_test(2'd1, "msa_1l");

        test_name = "bs_efm";
        efm = 1'b1;
        vid_en = 1'b1;
        wait_cycles(2);
        pulse_vs();                         // Video starts on this frame
        pulse_bs(`MSA_BS_CNT_EFM);

        test_name = "bs_nrm";
        efm = 1'b0;
        wait_cycles(4);
        pulse_bs(`MSA_BS_CNT_NRM);

        test_name = "end";
        vid_en = 1'b0;
        wait_cycles(8);
        $display("Summary: %0d beats checked, %0d checker errors, %0d testbench errors",
                 chk_cnt, chk_errs, tb_errs);
        if ((chk_errs == 0) && (tb_errs == 0))
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    initial
    begin
        #((TOTAL_CYC + MARGIN_CYC) * CLK_PER);
        $display("Timeout: the test sequence did not finish in %0d cycles",
                 TOTAL_CYC + MARGIN_CYC);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_msa_checker.sv
// ----------------------------------------
// MSA inserter checker
// Rebuilds the MSA image and the blanking
// start timing from the port activity and
// compares every link beat with lnk_out
// ----------------------------------------
`default_nettype none

`include "dptx_msa_params.svh"

module tb_msa_checker
(
    input wire                              LNK_CLK_IN,
    input wire                              LNK_RST_IN,
    input wire dptx_msa_pkg::lane_mode_t    lanes,
    input wire                              efm,
    input wire                              vid_en,
    input wire                              vs,
    input wire                              vbf,
    input wire                              bs,
    input wire [7:0]                        mvid_lsb,
    input wire dptx_msa_pkg::msa_msg_t      msg,
    input wire dptx_msa_pkg::lnk_beat_t     lnk_in,
    input wire dptx_msa_pkg::lnk_beat_t     lnk_out,
    input wire [95:0]                       test_name,
    output logic [31:0]                     err_cnt,
    output logic [31:0]                     chk_cnt,
    output logic [31:0]                     msa_cnt,
    output logic [31:0]                     seq_cnt
);

    timeunit 1ns;
    timeprecision 100ps;

    import dptx_msa_pkg::*;

    logic [`MSA_SYM_W-1:0]  img [0:`MSA_NUM_RAM-1][0:(1 << `MSA_RAM_ADR)-1];
    lnk_beat_t              exp_beat;
    int                     exp_lanes;      // Lanes compared for this beat
    logic                   armed;
    lane_mode_t             lanes_m;
    logic                   efm_m;
    logic                   en_m;
    logic                   vbf_m;
    logic                   bs_m;
    logic                   vs_m;
    logic                   run_m;
    logic                   ld_m;           // Idle period just elapsed
    logic [3:0]             vs_pipe;        // Vsync edge, aged per cycle
    logic [1:0]             cnt_m;
    logic [`MSA_RAM_ADR-1:0] wp_m;
    int                     idle_m;
    int                     rd_left;
    int                     rd_adr;
    int                     nl;
    int                     ln;
    int                     sb;

    function automatic int lanes_for(input lane_mode_t m);
        case (m)
            2'd3    : return 4;
            2'd2    : return 2;
            default : return 1;
        endcase
    endfunction

    function automatic int reads_for(input lane_mode_t m);
        case (m)
            2'd3    : return `MSA_RD_CNT_4L;
            2'd2    : return `MSA_RD_CNT_2L;
            default : return `MSA_RD_CNT_1L;
        endcase
    endfunction

    // Blanking start beat for a given countdown value
    function automatic lnk_beat_t seq_beat(input logic efm_f, input logic [1:0] cnt,
                                           input logic run_f, input logic vbf_f,
                                           input logic [7:0] mvid);
        sym_t       s0;
        sym_t       s1;
        logic [7:0] vbid;
        logic [7:0] mv;
        lnk_beat_t  b;
        vbid = run_f ? {7'd0, vbf_f} : `MSA_VBID_NOVID;
        mv   = run_f ? mvid : 8'h00;
        s0.raw = '0;
        s1.raw = '0;
        if (efm_f && (cnt == 2'd3))
        begin
            s0.raw = `MSA_SYM_BS;
            s1.raw = `MSA_SYM_BF;
        end
        else if (efm_f && (cnt == 2'd2))
        begin
            s0.raw = `MSA_SYM_BF;
            s1.raw = `MSA_SYM_BS;
        end
        else if (efm_f)
        begin
            s0.raw = {1'b0, vbid};
            s1.raw = {1'b0, mv};
        end
        else if (cnt == 2'd2)
        begin
            s0.raw = `MSA_SYM_BS;
            s1.raw = {1'b0, vbid};
        end
        else
            s0.raw = {1'b0, mv};                // Zero symbol follows
        for (int l = 0; l < `MSA_LANES; l++)
        begin
            b[l][0] = s0;
            b[l][1] = s1;
        end
        return b;
    endfunction

    initial
    begin
        err_cnt = 0;
        chk_cnt = 0;
        msa_cnt = 0;
        seq_cnt = 0;
        armed   = 1'b0;
    end

    // Expected beat for this edge, then the state update
    always @(posedge LNK_CLK_IN)
    begin
        if (LNK_RST_IN)
        begin
            {lanes_m, efm_m, en_m, vbf_m, bs_m, vs_m, run_m, ld_m} = '0;
            vs_pipe   = '0;
            cnt_m     = '0;
            wp_m      = '0;
            idle_m    = 0;
            rd_left   = 0;
            rd_adr    = 0;
            exp_beat  = lnk_in;
            exp_lanes = `MSA_LANES;
            armed     = 1'b0;
        end
        else
        begin
            if (vs_pipe[3])
            begin
                rd_left = reads_for(lanes_m);   // Fourth cycle after vs sampled
                rd_adr  = 0;
            end
            exp_lanes = `MSA_LANES;
            if (rd_left != 0)
            begin
                for (int l = 0; l < `MSA_LANES; l++)
                    for (int s = 0; s < `MSA_SPL; s++)
                        exp_beat[l][s].raw = img[l * `MSA_SPL + s][rd_adr];
                exp_lanes = lanes_for(lanes_m);
                rd_adr++;
                rd_left--;
                msa_cnt++;
            end
            else if (cnt_m != 2'd0)
            begin
                exp_beat = seq_beat(efm_m, cnt_m, run_m, vbf_m, mvid_lsb);
                seq_cnt++;
            end
            else
                exp_beat = lnk_in;

            // Lane is idx mod L, sublane (idx div L) mod 2
            if (msg.vld)
            begin
                nl = lanes_for(lanes_m);
                ln = msg.idx % nl;
                sb = (msg.idx / nl) % 2;
                img[ln * `MSA_SPL + sb][wp_m] = msg.dat[`MSA_SYM_W-1:0];
                if (msg.last)
                    wp_m = '0;
                else if ((ln == nl - 1) && (sb == 1))
                    wp_m = wp_m + 1'b1;
            end

            if (ld_m || (bs_m && run_m))
                cnt_m = efm_m ? 2'(`MSA_BS_CNT_EFM) : 2'(`MSA_BS_CNT_NRM);
            else if (cnt_m != 2'd0)
                cnt_m = cnt_m - 1'b1;

            ld_m = 1'b0;
            if (run_m)
                idle_m = 0;
            else if (idle_m >= `MSA_IDLE_MAX)
            begin
                idle_m = 0;
                ld_m   = 1'b1;
            end
            else
                idle_m = idle_m + `MSA_SPL;

            if (!en_m)
                run_m = 1'b0;
            else if (vs_pipe[1])
                run_m = 1'b1;

            vs_pipe = {vs_pipe[2:0], vs & ~vs_m};
            vs_m    = vs;
            lanes_m = lanes;
            efm_m   = efm;
            en_m    = vid_en;
            vbf_m   = vbf;
            bs_m    = bs;
            armed   = 1'b1;
        end
    end

    always @(negedge LNK_CLK_IN)
    begin : compare
        logic bad;
        bad = 1'b0;
        if (armed)
        begin
            chk_cnt++;
            for (int l = 0; l < exp_lanes; l++)
                if (exp_beat[l] !== lnk_out[l])
                    bad = 1'b1;
            if (bad)
            begin
                err_cnt++;
                $display("Fail %0s: expected %h actual %h", test_name, exp_beat, lnk_out);
            end
        end
    end

endmodule

`default_nettype wire
